// ==== project.f ====
tlb_cfg_pkg.sv
tlb_types_pkg.sv
tlb_way.sv
tlb_lru.sv
tlb_ctrl.sv
tlb_top.sv
tb_tlb.sv

// ==== tb_tlb.sv ====
// TLB testbench: directed and random lookups, fills and invalidates against a reference model
`timescale 1ns/1ns

module tb_tlb;

  logic clk;
  logic rst;
  logic touch;
  logic ready;
  tlb_types_pkg::tlb_lookup_req_t [tlb_cfg_pkg::port_count-1:0] lookup;
  tlb_types_pkg::tlb_lookup_rsp_t [tlb_cfg_pkg::port_count-1:0] result;
  tlb_types_pkg::tlb_write_req_t                                write;

  // reference state
  tlb_types_pkg::tlb_entry_t ref_entry [tlb_cfg_pkg::set_count][tlb_cfg_pkg::way_count];
  int   ref_age [tlb_cfg_pkg::set_count][tlb_cfg_pkg::way_count];
  logic ref_ready;
  int   sweep_cnt;
  int   errors;

  tlb_top UUT (
    .clk    (clk),
    .rst    (rst),
    .lookup (lookup),
    .touch  (touch),
    .write  (write),
    .result (result),
    .ready  (ready)
  );

  always #2 clk = ~clk;

  function automatic logic model_match(input tlb_types_pkg::tlb_entry_t e,
                                       input logic [tlb_cfg_pkg::vpn_bits-1:0] vpn,
                                       input logic [tlb_cfg_pkg::asid_bits-1:0] asid);
    return e.valid && (e.tag == vpn[tlb_cfg_pkg::vpn_bits-1:tlb_cfg_pkg::set_bits]) &&
           ((e.asid == asid) || e.perm.is_global);
  endfunction

  // expected response of one lookup port
  function automatic tlb_types_pkg::tlb_lookup_rsp_t expected_lookup(
    input tlb_types_pkg::tlb_lookup_req_t req);
    tlb_types_pkg::tlb_lookup_rsp_t rsp;
    int s;
    rsp = '0;
    s   = req.vpn[tlb_cfg_pkg::set_bits-1:0];
    for (int w = 0; w < tlb_cfg_pkg::way_count; w++) begin
      if (ref_ready && model_match(ref_entry[s][w], req.vpn, req.asid)) begin
        rsp.hit  = 1'b1;
        rsp.way  = 2'(w);
        rsp.perm = ref_entry[s][w].perm;
      end
    end
    return rsp;
  endfunction

  function automatic void clear_model();
    for (int s = 0; s < tlb_cfg_pkg::set_count; s++) begin
      for (int w = 0; w < tlb_cfg_pkg::way_count; w++) begin
        ref_entry[s][w] = '0;
        ref_age[s][w]   = w;
      end
    end
  endfunction

  // used way goes to 0, younger ways age by one
  function automatic void age_use(input int s, input int way);
    int a;
    a = ref_age[s][way];
    for (int k = 0; k < tlb_cfg_pkg::way_count; k++) begin
      if (k == way) ref_age[s][k] = 0;
      else if (ref_age[s][k] < a) ref_age[s][k] = ref_age[s][k] + 1;
    end
  endfunction

  function automatic void apply_write(input tlb_types_pkg::tlb_write_req_t wr);
    int s;
    int v;
    s = wr.vpn[tlb_cfg_pkg::set_bits-1:0];
    v = 0;
    if (wr.op == tlb_types_pkg::wr_fill) begin
      for (int k = 0; k < tlb_cfg_pkg::way_count; k++) begin
        if (ref_age[s][k] == tlb_cfg_pkg::way_count - 1) v = k;
      end
      ref_entry[s][v].valid = 1'b1;
      ref_entry[s][v].asid  = wr.asid;
      ref_entry[s][v].tag   = wr.vpn[tlb_cfg_pkg::vpn_bits-1:tlb_cfg_pkg::set_bits];
      ref_entry[s][v].perm  = wr.perm;
      age_use(s, v);
    end else begin
      for (int k = 0; k < tlb_cfg_pkg::way_count; k++) begin
        if (model_match(ref_entry[s][k], wr.vpn, wr.asid)) ref_entry[s][k].valid = 1'b0;
      end
    end
  endfunction

  // model follows the DUT edge by edge
  always @(posedge clk) begin : model_update
    tlb_types_pkg::tlb_lookup_rsp_t rsp0;
    if (rst) begin
      sweep_cnt = 0;
      ref_ready = 1'b0;
      clear_model();
    end else if (!ref_ready) begin
      sweep_cnt = sweep_cnt + 1;
      if (sweep_cnt == tlb_cfg_pkg::set_count) begin
        ref_ready = 1'b1;
        clear_model();
      end
    end else begin
      rsp0 = expected_lookup(lookup[0]);
      if (write.en) apply_write(write);
      else if (touch && rsp0.hit) age_use(lookup[0].vpn[tlb_cfg_pkg::set_bits-1:0], rsp0.way);
    end
  end

  // outputs are sampled mid-cycle
  always @(negedge clk) begin : compare
    tlb_types_pkg::tlb_lookup_rsp_t exp_rsp;
    if (!rst) begin
      if (ready !== ref_ready) begin
        errors++;
        $display("ERROR at %0t ns: ready is %b, expected %b", $time, ready, ref_ready);
      end
      for (int p = 0; p < tlb_cfg_pkg::port_count; p++) begin
        exp_rsp = expected_lookup(lookup[p]);
        if (result[p].hit !== exp_rsp.hit ||
            (exp_rsp.hit && (result[p].way !== exp_rsp.way ||
                             result[p].perm !== exp_rsp.perm))) begin
          errors++;
          $display("ERROR at %0t ns: port %0d vpn %h asid %h got %b/%0d/%h, expected %b/%0d/%h",
                   $time, p, lookup[p].vpn, lookup[p].asid, result[p].hit, result[p].way,
                   result[p].perm, exp_rsp.hit, exp_rsp.way, exp_rsp.perm);
        end
      end
    end
  end

  function automatic logic [tlb_cfg_pkg::vpn_bits-1:0] make_vpn(input int tag, input int s);
    return {tlb_cfg_pkg::tag_bits'(tag), tlb_cfg_pkg::set_bits'(s)};
  endfunction

  function automatic tlb_types_pkg::tlb_lookup_req_t make_req(input int tag, input int s,
                                                              input int asid);
    tlb_types_pkg::tlb_lookup_req_t rq;
    rq.vpn  = make_vpn(tag, s);
    rq.asid = tlb_cfg_pkg::asid_bits'(asid);
    return rq;
  endfunction

  function automatic tlb_types_pkg::tlb_perm_t make_perm(input int ppn, input logic glob);
    tlb_types_pkg::tlb_perm_t pm;
    pm.ppn       = tlb_cfg_pkg::ppn_bits'(ppn);
    pm.is_global = glob;
    pm.writable  = 1'b1;
    pm.user      = 1'b0;
    return pm;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_cycle(input tlb_types_pkg::tlb_write_req_t wr,
                             input tlb_types_pkg::tlb_lookup_req_t rq0,
                             input tlb_types_pkg::tlb_lookup_req_t rq1, input logic t);
    next_cycle();
    write     = wr;
    lookup[0] = rq0;
    lookup[1] = rq1;
    touch     = t;
  endtask

  task automatic send_write(input tlb_types_pkg::tlb_write_op_t op, input int tag, input int s,
                            input int asid, input tlb_types_pkg::tlb_perm_t pm);
    tlb_types_pkg::tlb_write_req_t wr;
    wr.en   = 1'b1;
    wr.op   = op;
    wr.vpn  = make_vpn(tag, s);
    wr.asid = tlb_cfg_pkg::asid_bits'(asid);
    wr.perm = pm;
    drive_cycle(wr, '0, '0, 1'b0);
  endtask

  // hand-derived expectation on both ports
  task automatic probe(input string what, input tlb_types_pkg::tlb_lookup_req_t rq,
                       input logic exp_hit, input int exp_way,
                       input tlb_types_pkg::tlb_perm_t exp_perm);
    drive_cycle('0, rq, rq, 1'b0);
    @(negedge clk);
    for (int p = 0; p < tlb_cfg_pkg::port_count; p++) begin
      if (result[p].hit !== exp_hit ||
          (exp_hit && (result[p].way !== 2'(exp_way) || result[p].perm !== exp_perm))) begin
        errors++;
        $display("ERROR at %0t ns: %s, port %0d got hit %b way %0d, expected hit %b way %0d",
                 $time, what, p, result[p].hit, result[p].way, exp_hit, exp_way);
      end
    end
  endtask

  task automatic wait_ready(output logic seen, output int low_cycles);
    seen       = 1'b0;
    low_cycles = 0;
    for (int i = 0; i < 64 && !seen; i++) begin
      @(negedge clk);
      if (ready) begin
        seen = 1'b1;
      end else begin
        low_cycles++;
        // lookups during the sweep must all miss
        next_cycle();
        lookup[0] = make_req($urandom, $urandom, $urandom);
        lookup[1] = make_req($urandom, $urandom, $urandom);
      end
    end
  endtask

  task automatic directed_tests();
    tlb_types_pkg::tlb_perm_t pa;
    tlb_types_pkg::tlb_perm_t pg;
    pa = make_perm('h12345, 1'b0);
    pg = make_perm('h0abcd, 1'b1);
    // fill then hit on both ports, neighbor misses
    send_write(tlb_types_pkg::wr_fill, 'h12, 5, 1, pa);
    probe("filled vpn", make_req('h12, 5, 1), 1'b1, 3, pa);
    probe("other vpn", make_req('h13, 5, 1), 1'b0, 0, pa);
    // asid and global
    probe("wrong asid", make_req('h12, 5, 2), 1'b0, 0, pa);
    send_write(tlb_types_pkg::wr_fill, 'h44, 6, 1, pg);
    probe("global, other asid", make_req('h44, 6, 9), 1'b1, 3, pg);
    probe("global, own asid", make_req('h44, 6, 1), 1'b1, 3, pg);
    // five fills, first one is evicted
    for (int t = 1; t <= 5; t++) send_write(tlb_types_pkg::wr_fill, t, 9, 3, make_perm(t, 1'b0));
    probe("evicted oldest", make_req(1, 9, 3), 1'b0, 0, pa);
    probe("fifth fill", make_req(5, 9, 3), 1'b1, 3, make_perm(5, 1'b0));
    // touching the oldest moves eviction to the next one
    for (int t = 1; t <= 4; t++) send_write(tlb_types_pkg::wr_fill, t, 10, 3, make_perm(t, 1'b0));
    drive_cycle('0, make_req(1, 10, 3), '0, 1'b1);
    send_write(tlb_types_pkg::wr_fill, 5, 10, 3, make_perm(5, 1'b0));
    probe("touched kept", make_req(1, 10, 3), 1'b1, 3, make_perm(1, 1'b0));
    probe("next oldest evicted", make_req(2, 10, 3), 1'b0, 0, pa);
    probe("fill after touch", make_req(5, 10, 3), 1'b1, 2, make_perm(5, 1'b0));
    // set 9 holds tag 5/2/3/4 in ways 3/2/1/0
    send_write(tlb_types_pkg::wr_invalidate, 3, 9, 3, '0);
    probe("invalidated", make_req(3, 9, 3), 1'b0, 0, pa);
    probe("neighbor kept", make_req(2, 9, 3), 1'b1, 2, make_perm(2, 1'b0));
    probe("neighbor kept", make_req(4, 9, 3), 1'b1, 0, make_perm(4, 1'b0));
    send_write(tlb_types_pkg::wr_invalidate, 'h77, 9, 3, '0);
    send_write(tlb_types_pkg::wr_invalidate, 4, 9, 5, '0);
    probe("absent invalidate", make_req(2, 9, 3), 1'b1, 2, make_perm(2, 1'b0));
    probe("asid mismatch invalidate", make_req(4, 9, 3), 1'b1, 0, make_perm(4, 1'b0));
  endtask

  // a tag not held by any valid entry of the set, or -1
  function automatic int free_tag(input int s);
    int t;
    logic used;
    for (int i = 0; i < 8; i++) begin
      t    = $urandom % 16;
      used = 1'b0;
      for (int w = 0; w < tlb_cfg_pkg::way_count; w++) begin
        if (ref_entry[s][w].valid && ref_entry[s][w].tag == t) used = 1'b1;
      end
      if (!used) return t;
    end
    return -1;
  endfunction

  function automatic tlb_types_pkg::tlb_lookup_req_t pick_lookup();
    int s;
    int w;
    s = $urandom % 4;
    w = $urandom % tlb_cfg_pkg::way_count;
    if ($urandom % 10 < 6) begin
      if ($urandom % 2) return make_req(ref_entry[s][w].tag, s, ref_entry[s][w].asid);
      return make_req(ref_entry[s][w].tag, s, $urandom % 4);
    end
    return make_req($urandom % 16, s, $urandom % 4);
  endfunction

  task automatic random_run(input int cycles);
    tlb_types_pkg::tlb_write_req_t wr;
    int roll;
    int s;
    int w;
    int t;
    for (int c = 0; c < cycles; c++) begin
      next_cycle();
      wr   = '0;
      roll = $urandom % 100;
      s    = $urandom % 4;
      if (roll < 30) begin
        t = free_tag(s);
        if (t >= 0) begin
          wr.en   = 1'b1;
          wr.op   = tlb_types_pkg::wr_fill;
          wr.vpn  = make_vpn(t, s);
          wr.asid = tlb_cfg_pkg::asid_bits'($urandom % 4);
          wr.perm = make_perm($urandom, ($urandom % 4) == 0);
        end
      end else if (roll < 40) begin
        w       = $urandom % tlb_cfg_pkg::way_count;
        wr.en   = 1'b1;
        wr.op   = tlb_types_pkg::wr_invalidate;
        wr.vpn  = make_vpn(ref_entry[s][w].tag, s);
        wr.asid = ($urandom % 2) ? ref_entry[s][w].asid : tlb_cfg_pkg::asid_bits'($urandom % 4);
      end
      write     = wr;
      lookup[0] = pick_lookup();
      lookup[1] = pick_lookup();
      touch     = $urandom % 2;
    end
    drive_cycle('0, '0, '0, 1'b0);
  endtask

  initial begin : main
    logic seen;
    int   low_cycles;
    void'($urandom(32'heb5feddf));
    clk    = 1'b0;
    rst    = 1'b1;
    touch  = 1'b0;
    write  = '0;
    lookup = '0;
    errors = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_ready(seen, low_cycles);
    if (!seen) begin
      $display("timeout: ready never rose after reset");
      $display("Test failed");
      $finish;
    end else begin
      if (low_cycles != tlb_cfg_pkg::set_count) begin
        errors++;
        $display("ERROR at %0t ns: ready low for %0d cycles, expected %0d",
                 $time, low_cycles, tlb_cfg_pkg::set_count);
      end
      directed_tests();
      random_run(400);
      @(negedge clk);
      $display("run complete, %0d errors", errors);
      if (errors == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

// ==== tlb_cfg_pkg.sv ====
// TLB geometry: way and set counts, field widths and port count

package tlb_cfg_pkg;

  // associativity and depth
  localparam int way_count = 4;
  localparam int set_count = 16;

  // set index is the low vpn bits
  localparam int set_bits = 4;

  // independent combinational lookup ports
  localparam int port_count = 2;

  // virtual side
  localparam int vpn_bits = 20;

  // vpn bits above the set index
  localparam int tag_bits = vpn_bits - set_bits;

  // address space id carried by every lookup and write
  localparam int asid_bits = 8;

  // physical side
  localparam int ppn_bits = 20;

  // per-way LRU age, oldest is way_count-1
  localparam int age_bits = 2;

endpackage

// ==== tlb_ctrl.sv ====
// TLB control: post-reset sweep FSM and decode of writes into per-way enables
`timescale 1ns/1ns

module tlb_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  tlb_types_pkg::tlb_write_req_t     write,
  input  logic [tlb_cfg_pkg::way_count-1:0] write_hit,
  input  logic [1:0]                        victim,
  output logic [tlb_cfg_pkg::way_count-1:0] wr_en,
  output logic                              fill_en,
  output logic                              sweep,
  output logic [tlb_cfg_pkg::set_bits-1:0]  sweep_set,
  output logic                              ready
);

  tlb_types_pkg::tlb_ctrl_state_t   state;
  logic [tlb_cfg_pkg::set_bits-1:0] sweep_cnt;
  logic                             wr_active;

  // one set per cycle, leave on the last set
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= tlb_types_pkg::st_sweep;
      sweep_cnt <= '0;
    end else begin
      case (state)
        tlb_types_pkg::st_sweep: begin
          sweep_cnt <= sweep_cnt + 1'b1;
          if (sweep_cnt == tlb_cfg_pkg::set_bits'(tlb_cfg_pkg::set_count - 1)) begin
            state <= tlb_types_pkg::st_run;
          end
        end
        default: begin
          state <= tlb_types_pkg::st_run;
        end
      endcase
    end
  end

  assign sweep     = state == tlb_types_pkg::st_sweep;
  assign sweep_set = sweep_cnt;
  assign ready     = state == tlb_types_pkg::st_run;

  // writes are dropped until the sweep is done
  assign wr_active = ready && write.en;
  assign fill_en   = wr_active && (write.op == tlb_types_pkg::wr_fill);

  always_comb begin
    wr_en = '0;
    if (fill_en) begin
      wr_en[victim] = 1'b1;
    end else if (wr_active) begin
      // invalidate every way that matches
      wr_en = write_hit;
    end
  end

endmodule

// ==== tlb_lru.sv ====
// TLB LRU: per-set way ages, victim selection and age update on hit or fill
`timescale 1ns/1ns

module tlb_lru (
  input  logic                             clk,
  input  logic                             touch_en,
  input  logic [tlb_cfg_pkg::set_bits-1:0] touch_set,
  input  logic [1:0]                       touch_way,
  input  logic                             fill_en,
  input  logic [tlb_cfg_pkg::set_bits-1:0] fill_set,
  input  logic                             sweep,
  input  logic [tlb_cfg_pkg::set_bits-1:0] sweep_set,
  output logic [1:0]                       victim
);

  // one age per way in every set
  logic [tlb_cfg_pkg::way_count-1:0][tlb_cfg_pkg::age_bits-1:0]
    age_ram [tlb_cfg_pkg::set_count];

  logic [tlb_cfg_pkg::way_count-1:0][tlb_cfg_pkg::age_bits-1:0] fill_ages;
  logic [tlb_cfg_pkg::way_count-1:0][tlb_cfg_pkg::age_bits-1:0] cur_ages;
  logic [tlb_cfg_pkg::way_count-1:0][tlb_cfg_pkg::age_bits-1:0] new_ages;
  logic [tlb_cfg_pkg::way_count-1:0][tlb_cfg_pkg::age_bits-1:0] init_ages;

  logic [tlb_cfg_pkg::set_bits-1:0] upd_set;
  logic [1:0]                       upd_way;
  logic [tlb_cfg_pkg::age_bits-1:0] hit_age;
  logic                             upd_en;

  // victim is the way holding the oldest age
  always_comb begin
    fill_ages = age_ram[fill_set];
    victim    = '0;
    for (int k = 0; k < tlb_cfg_pkg::way_count; k++) begin
      if (fill_ages[k] == tlb_cfg_pkg::age_bits'(tlb_cfg_pkg::way_count - 1)) begin
        victim = 2'(k);
      end
    end
  end

  // fill wins over touch, so a write in the same cycle owns the update
  assign upd_en  = fill_en || touch_en;
  assign upd_set = fill_en ? fill_set : touch_set;
  assign upd_way = fill_en ? victim : touch_way;

  always_comb begin
    cur_ages = age_ram[upd_set];
    hit_age  = cur_ages[upd_way];
    for (int k = 0; k < tlb_cfg_pkg::way_count; k++) begin
      if (2'(k) == upd_way) begin
        new_ages[k] = '0;
      end else if (cur_ages[k] < hit_age) begin
        // younger than the hit way, ages by one
        new_ages[k] = cur_ages[k] + 1'b1;
      end else begin
        new_ages[k] = cur_ages[k];
      end
    end
  end

  // way k starts at age k
  always_comb begin
    for (int k = 0; k < tlb_cfg_pkg::way_count; k++) begin
      init_ages[k] = tlb_cfg_pkg::age_bits'(k);
    end
  end

  always_ff @(posedge clk) begin
    if (sweep) begin
      age_ram[sweep_set] <= init_ages;
    end else if (upd_en) begin
      age_ram[upd_set] <= new_ages;
    end
  end

endmodule

// ==== tlb_top.sv ====
// TLB top: four ways, shared LRU and control, per-port hit merge and data select
`timescale 1ns/1ns

module tlb_top (
  input  logic                                                          clk,
  input  logic                                                          rst,
  input  tlb_types_pkg::tlb_lookup_req_t [tlb_cfg_pkg::port_count-1:0]  lookup,
  input  logic                                                          touch,
  input  tlb_types_pkg::tlb_write_req_t                                 write,
  output tlb_types_pkg::tlb_lookup_rsp_t [tlb_cfg_pkg::port_count-1:0]  result,
  output logic                                                          ready
);

  logic [tlb_cfg_pkg::port_count-1:0] way_port_hit [tlb_cfg_pkg::way_count];
  tlb_types_pkg::tlb_perm_t [tlb_cfg_pkg::port_count-1:0]
    way_perm [tlb_cfg_pkg::way_count];

  logic [tlb_cfg_pkg::way_count-1:0] write_hit;
  logic [tlb_cfg_pkg::way_count-1:0] wr_en;
  logic                              fill_en;
  logic                              sweep;
  logic [tlb_cfg_pkg::set_bits-1:0]  sweep_set;
  logic [1:0]                        victim;
  logic                              touch_en;

  for (genvar k = 0; k < tlb_cfg_pkg::way_count; k++) begin : g_way
    tlb_way u_way (
      .clk       (clk),
      .lookup    (lookup),
      .write     (write),
      .wr_en     (wr_en[k]),
      .sweep     (sweep),
      .sweep_set (sweep_set),
      .port_hit  (way_port_hit[k]),
      .port_perm (way_perm[k]),
      .write_hit (write_hit[k])
    );
  end

  // hit merge with one-hot AND-OR select of way index and payload
  always_comb begin
    for (int p = 0; p < tlb_cfg_pkg::port_count; p++) begin
      result[p] = '0;
      for (int k = 0; k < tlb_cfg_pkg::way_count; k++) begin
        result[p].hit  = result[p].hit | way_port_hit[k][p];
        result[p].way  = result[p].way | (2'(k) & {2{way_port_hit[k][p]}});
        result[p].perm = result[p].perm |
          ({$bits(tlb_types_pkg::tlb_perm_t){way_port_hit[k][p]}} & way_perm[k][p]);
      end
      // nothing hits before the sweep completes
      result[p].hit = result[p].hit & ready;
    end
  end

  // a write in the same cycle takes the age update
  assign touch_en = touch && result[0].hit && !write.en;

  tlb_lru u_lru (
    .clk       (clk),
    .touch_en  (touch_en),
    .touch_set (lookup[0].vpn[tlb_cfg_pkg::set_bits-1:0]),
    .touch_way (result[0].way),
    .fill_en   (fill_en),
    .fill_set  (write.vpn[tlb_cfg_pkg::set_bits-1:0]),
    .sweep     (sweep),
    .sweep_set (sweep_set),
    .victim    (victim)
  );

  tlb_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .write     (write),
    .write_hit (write_hit),
    .victim    (victim),
    .wr_en     (wr_en),
    .fill_en   (fill_en),
    .sweep     (sweep),
    .sweep_set (sweep_set),
    .ready     (ready)
  );

endmodule

// ==== tlb_types_pkg.sv ====
// TLB data types: entries, lookup and write requests, responses and FSM states

package tlb_types_pkg;

  // translation payload returned on a hit
  typedef struct packed {
    logic [tlb_cfg_pkg::ppn_bits-1:0] ppn;
    // matches any asid when set
    logic                             is_global;
    logic                             writable;
    logic                             user;
  } tlb_perm_t;

  // one stored translation
  typedef struct packed {
    logic                              valid;
    logic [tlb_cfg_pkg::asid_bits-1:0] asid;
    logic [tlb_cfg_pkg::tag_bits-1:0]  tag;
    tlb_perm_t                         perm;
  } tlb_entry_t;

  typedef struct packed {
    logic [tlb_cfg_pkg::vpn_bits-1:0]  vpn;
    logic [tlb_cfg_pkg::asid_bits-1:0] asid;
  } tlb_lookup_req_t;

  typedef struct packed {
    logic       hit;
    logic [1:0] way;
    tlb_perm_t  perm;
  } tlb_lookup_rsp_t;

  typedef enum logic [0:0] {
    wr_fill       = 1'b0,
    wr_invalidate = 1'b1
  } tlb_write_op_t;

  // single-cycle write strobe
  typedef struct packed {
    logic                              en;
    tlb_write_op_t                     op;
    logic [tlb_cfg_pkg::vpn_bits-1:0]  vpn;
    logic [tlb_cfg_pkg::asid_bits-1:0] asid;
    tlb_perm_t                         perm;
  } tlb_write_req_t;

  typedef enum logic [0:0] {
    st_sweep = 1'b0,
    st_run   = 1'b1
  } tlb_ctrl_state_t;

endpackage

// ==== tlb_way.sv ====
// TLB way: entry RAM with per-port and write-side tag compare, and entry writes
`timescale 1ns/1ns

module tlb_way (
  input  logic                                                    clk,
  input  tlb_types_pkg::tlb_lookup_req_t [tlb_cfg_pkg::port_count-1:0] lookup,
  input  tlb_types_pkg::tlb_write_req_t                           write,
  input  logic                                                    wr_en,
  input  logic                                                    sweep,
  input  logic [tlb_cfg_pkg::set_bits-1:0]                        sweep_set,
  output logic [tlb_cfg_pkg::port_count-1:0]                      port_hit,
  output tlb_types_pkg::tlb_perm_t [tlb_cfg_pkg::port_count-1:0]  port_perm,
  output logic                                                    write_hit
);

  // one entry per set
  tlb_types_pkg::tlb_entry_t entry_ram [tlb_cfg_pkg::set_count];

  tlb_types_pkg::tlb_entry_t rd_entry [tlb_cfg_pkg::port_count];

  logic [tlb_cfg_pkg::set_bits-1:0] wr_set;
  tlb_types_pkg::tlb_entry_t        wr_entry;
  tlb_types_pkg::tlb_entry_t        new_entry;

  // valid, same tag, and same asid unless the entry is global
  function automatic logic entry_match(
    input tlb_types_pkg::tlb_entry_t         e,
    input logic [tlb_cfg_pkg::vpn_bits-1:0]  vpn,
    input logic [tlb_cfg_pkg::asid_bits-1:0] asid
  );
    logic tag_eq;
    logic asid_ok;
    tag_eq  = e.tag == vpn[tlb_cfg_pkg::vpn_bits-1:tlb_cfg_pkg::set_bits];
    asid_ok = (e.asid == asid) || e.perm.is_global;
    return e.valid && tag_eq && asid_ok;
  endfunction

  // combinational lookup ports
  for (genvar p = 0; p < tlb_cfg_pkg::port_count; p++) begin : g_port
    assign rd_entry[p]  = entry_ram[lookup[p].vpn[tlb_cfg_pkg::set_bits-1:0]];
    assign port_hit[p]  = entry_match(rd_entry[p], lookup[p].vpn, lookup[p].asid);
    assign port_perm[p] = rd_entry[p].perm;
  end

  // write-side compare for invalidate
  assign wr_set    = write.vpn[tlb_cfg_pkg::set_bits-1:0];
  assign wr_entry  = entry_ram[wr_set];
  assign write_hit = entry_match(wr_entry, write.vpn, write.asid);

  always_comb begin
    if (write.op == tlb_types_pkg::wr_fill) begin
      new_entry.valid = 1'b1;
      new_entry.asid  = write.asid;
      new_entry.tag   = write.vpn[tlb_cfg_pkg::vpn_bits-1:tlb_cfg_pkg::set_bits];
      new_entry.perm  = write.perm;
    end else begin
      // invalidate keeps the old contents and drops valid
      new_entry       = wr_entry;
      new_entry.valid = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sweep) begin
      entry_ram[sweep_set] <= '0;
    end else if (wr_en) begin
      entry_ram[wr_set] <= new_entry;
    end
  end

endmodule
